// File: bench/alu_checker.sv
// ALU output checker
// bound assertions on flag byte, write-enable and busy
`default_nettype none
`timescale 1ns/100ps

module alu_checker (
    input logic                clk,
    input logic                rst,
    input logic [7:0]          flags,
    input alu_pkg::alu_width_t alu_we,
    input logic                busy
);
    import alu_pkg::*;

    a_flag_gaps: assert property (@(posedge clk) disable iff (rst)
        flags[5] == 1'b0 && flags[3] == 1'b0)
        else $error("flag byte bit 5 or bit 3 is set");

    a_no_we_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> alu_we == W_NONE)
        else $error("alu_we active while busy");

    a_we_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(alu_we))
        else $error("alu_we is not zero or one-hot");

    // first edge out of reset
    a_idle_after_rst: assert property (@(posedge clk) $fell(rst) |-> !busy)
        else $error("busy high right after reset release");

endmodule

bind alu_top alu_checker u_checker (
    .clk    (clk),
    .rst    (rst),
    .flags  (flags),
    .alu_we (alu_we),
    .busy   (busy)
);

`default_nettype wire

// File: bench/alu_tb.sv
// ALU testbench
// replays the vector file, a carry setup op ahead of each vector
`default_nettype none
`timescale 1ns/100ps

module alu_tb;
    import alu_pkg::*;

    logic       clk;
    logic       rst;
    alu_req_t   req;
    data_t      dout;
    logic [7:0] flags;
    alu_width_t alu_we;
    logic       busy;

    int errors;
    int tests;
    bit aborted;

    alu_top dut0 (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .dout   (dout),
        .flags  (flags),
        .alu_we (alu_we),
        .busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic data_t width_mask(alu_width_t w);
        case (w)
            W_BYTE:  return 32'h0000_00ff;
            W_WORD:  return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // cycles with busy high, count field 0 stands for 16
    function automatic logic [31:0] busy_expected(alu_sel_t sel, data_t src);
        logic [31:0] steps;
        if (!(sel inside {ALU_RLC, ALU_RRC, ALU_RL, ALU_RR,
                          ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL}))
            return 32'd0;
        steps = (src[3:0] == 4'd0) ? 32'd16 : {28'd0, src[3:0]};
        return steps - 32'd1;
    endfunction

    task automatic apply_req(input alu_sel_t sel, input alu_width_t w, input data_t op0,
                             input data_t op1, input data_t imm, input logic sel_imm);
        req.sel     = sel;
        req.w       = w;
        req.op0     = op0;
        req.op1     = op1;
        req.imm     = imm;
        req.sel_imm = sel_imm;
    endtask

    task automatic wait_idle(output logic [31:0] cycles, output bit timed_out);
        cycles    = 32'd0;
        timed_out = 1'b0;
        while (busy && !timed_out) begin
            cycles = cycles + 32'd1;
            if (cycles > 32'd40)
                timed_out = 1'b1;
            else
                @(negedge clk);
        end
    endtask

    task automatic check_field(input int num, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: test %0d %s got %h expected %h",
                     $time, num, name, got, exp);
            errors++;
        end
    endtask

    initial begin
        int          fd;
        int          rc;
        int          num;
        int          start_errors;
        string       line;
        logic [31:0] sel_f, w_f, op0, op1, imm, sel_imm_f, cy_f;
        logic [31:0] exp_dout, exp_flags, exp_we, busy_n, src;
        bit          tout;

        errors  = 0;
        tests   = 0;
        aborted = 1'b0;
        rst     = 1'b1;
        req     = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("bench/alu_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file bench/alu_testdata.txt");
            errors++;
        end else begin
            while (!aborted && !$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc <= 0 || line[0] == "#")
                    continue;
                rc = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", num, sel_f, w_f,
                             op0, op1, imm, sel_imm_f, cy_f, exp_dout, exp_flags, exp_we);
                if (rc != 11)
                    continue;
                start_errors = errors;
                apply_req(cy_f[0] ? ALU_SCF : ALU_RCF, W_BYTE, '0, '0, '0, 1'b0);
                @(negedge clk);
                apply_req(sel_f[6:0], w_f[2:0], op0, op1, imm, sel_imm_f[0]);
                @(negedge clk);
                req.w = W_NONE;  // caller holds off while busy
                wait_idle(busy_n, tout);
                if (tout) begin
                    $display("test %0d: busy stayed high past the timeout", num);
                    errors++;
                    aborted = 1'b1;
                end else begin
                    src = sel_imm_f[0] ? imm : op1;
                    check_field(num, "dout", dout & width_mask(w_f[2:0]), exp_dout);
                    check_field(num, "flags", {24'd0, flags}, exp_flags);
                    check_field(num, "alu_we", {29'd0, alu_we}, exp_we);
                    check_field(num, "busy cycles", busy_n, busy_expected(sel_f[6:0], src));
                    tests++;
                    if (errors == start_errors)
                        $display("test %0d: ok", num);
                    else
                        $display("test %0d: FAILED", num);
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d checks failed", tests, errors);
        if (errors == 0 && !aborted && tests > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/alu_testdata.txt
# num sel w op0 op1 imm sel_imm carry, then expected dout (masked to w), flags, alu_we
# all fields hex except num, carry is set by SCF/RCF ahead of the vector
1 01 1 0000007f 00000001 00000000 0 0 00000080 94 1
2 02 1 000000ff 00000012 00000001 1 1 00000001 11 1
3 01 2 00008000 00008000 00000000 0 1 00000000 45 2
4 01 4 7fffffff 00000001 00000000 0 0 80000000 94 4
5 03 1 00000010 00000001 00000000 0 0 0000000f 12 1
6 04 1 00000080 00000055 00000000 1 1 0000007f 16 1
7 03 2 00000000 00000001 00000000 0 0 0000ffff 93 2
8 05 1 00000042 00000042 00000000 0 0 000000ff 42 0
9 05 2 00001234 00000000 00002345 1 1 0000ffff 93 0
10 06 1 000000f0 0000003c 00000000 0 1 00000030 14 1
11 07 2 00000100 00000001 00000000 0 0 00000101 04 2
12 08 4 ffff0000 00000000 8000ffff 1 1 7fffffff 04 4
13 08 1 0000005a 0000005a 00000000 0 1 00000000 44 1
14 09 1 00000000 0000005a 00000000 0 0 000000a5 56 1
15 0a 1 00000000 00000000 00000000 0 0 000000a5 45 0
16 0c 2 00000000 00000000 00000000 0 1 0000ffa5 44 0
17 0b 1 00000000 00000000 00000000 0 1 000000a5 44 0
18 00 2 00001111 00000000 0000beef 1 1 0000beef 45 2
19 00 1 00000000 12345678 00000000 0 0 00000078 44 1
20 0d 1 00000081 00000001 00000000 0 0 00000003 05 1
21 0e 1 00000001 00000000 00000005 1 0 00000008 00 1
22 0f 1 00000080 00000000 00000000 0 1 00000060 04 1
23 10 2 00000003 00000005 00000000 0 0 00003000 04 2
24 11 2 00008001 00000001 00000000 0 0 00000002 01 2
25 12 1 00000090 00000000 00000005 1 1 000000fc 85 1
26 13 2 0000abcd 00000010 00000000 0 1 00000000 45 2
27 14 1 00000001 00000001 00000000 0 1 00000000 45 1
28 0d 2 00008421 00000005 00000000 0 0 00008430 84 2
29 0e 2 00001234 00000000 00000000 0 1 00001234 00 2
30 11 1 0000003c 00000005 00000000 0 0 00000080 81 1
31 14 2 0000f000 00000005 00000000 0 1 00000780 04 2
32 10 1 00000002 00000001 00000000 0 1 00000081 84 1
33 0f 2 00004000 00000001 00000000 0 1 00008001 84 2
34 12 2 00008000 00000000 00000000 0 0 0000ffff 85 2
35 00 1 00000000 0000cafe 00000000 0 1 000000fe 85 1

// File: rtl/alu_adder.sv
// ALU adder/subtractor
// nibble-chained add and subtract with half-carry, width carry and overflow
`default_nettype none
`timescale 1ns/100ps

module alu_adder (
    input  alu_pkg::alu_req_t   req,
    input  logic                carry,
    output alu_pkg::data_t      sum,
    output alu_pkg::alu_flags_t nx_flags
);
    import alu_pkg::*;

    data_t       src;
    logic        is_sub, cin;
    logic        h, c0, c1, c2;
    logic [32:0] ext_a, ext_b, ext_r;

    function automatic logic [32:0] sext(data_t x, alu_width_t w);
        case (w)
            W_BYTE:  return {{25{x[7]}}, x[7:0]};
            W_WORD:  return {{17{x[15]}}, x[15:0]};
            default: return {x[31], x};
        endcase
    endfunction

    always_comb begin
        src    = alu_src(req);
        is_sub = req.sel inside {ALU_SUB, ALU_SBC, ALU_CP};
        cin    = carry && (req.sel == ALU_ADC || req.sel == ALU_SBC);
        ext_a  = sext(req.op0, req.w);
        ext_b  = sext(src, req.w);
        if (is_sub) begin  // borrows ripple up the chain
            {h,  sum[3:0]}   = {1'b0, req.op0[3:0]}   - {1'b0, src[3:0]}   - {4'd0, cin};
            {c0, sum[7:4]}   = {1'b0, req.op0[7:4]}   - {1'b0, src[7:4]}   - {4'd0, h};
            {c1, sum[15:8]}  = {1'b0, req.op0[15:8]}  - {1'b0, src[15:8]}  - {8'd0, c0};
            {c2, sum[31:16]} = {1'b0, req.op0[31:16]} - {1'b0, src[31:16]} - {16'd0, c1};
            ext_r = ext_a - ext_b - {32'd0, cin};
        end else begin
            {h,  sum[3:0]}   = {1'b0, req.op0[3:0]}   + {1'b0, src[3:0]}   + {4'd0, cin};
            {c0, sum[7:4]}   = {1'b0, req.op0[7:4]}   + {1'b0, src[7:4]}   + {4'd0, h};
            {c1, sum[15:8]}  = {1'b0, req.op0[15:8]}  + {1'b0, src[15:8]}  + {8'd0, c0};
            {c2, sum[31:16]} = {1'b0, req.op0[31:16]} + {1'b0, src[31:16]} + {16'd0, c1};
            ext_r = ext_a + ext_b + {32'd0, cin};
        end

        nx_flags.s = w_msb(sum, req.w);
        nx_flags.z = w_zero(sum, req.w);
        nx_flags.h = h;
        nx_flags.v = ext_r[32] ^ w_msb(sum, req.w);  // true sign vs truncated sign
        nx_flags.n = is_sub;
        case (req.w)
            W_BYTE:  nx_flags.c = c0;
            W_WORD:  nx_flags.c = c1;
            default: nx_flags.c = c2;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/alu_flags.sv
// ALU output stage
// result mux, shift flags, result and flag registers, write-enable
`default_nettype none
`timescale 1ns/100ps

module alu_flags (
    input  logic                clk,
    input  logic                rst,
    input  alu_pkg::alu_req_t   req,
    input  alu_pkg::data_t      add_rslt,
    input  alu_pkg::data_t      logic_rslt,
    input  alu_pkg::data_t      sh_work,
    input  alu_pkg::alu_flags_t add_flags,
    input  alu_pkg::alu_flags_t logic_flags,
    input  logic                sh_cout,
    input  logic                sh_done,
    input  logic                sh_busy,
    output alu_pkg::alu_flags_t cur,
    output alu_pkg::data_t      dout,
    output logic [7:0]          flags,
    output alu_pkg::alu_width_t alu_we
);
    import alu_pkg::*;

    alu_flags_t flag_q, nx_flags;
    alu_width_t hold_w, op_w;
    data_t      nx_rslt;
    logic       accept, upd, wr_data;

    assign accept = req.w != W_NONE && !sh_busy;
    assign upd    = sh_done || (accept && !is_shift(req.sel));  // long shifts wait
    assign op_w   = sh_busy ? hold_w : req.w;

    always_comb begin
        if (sh_done) begin
            nx_rslt    = sh_work;
            nx_flags.s = w_msb(sh_work, op_w);
            nx_flags.z = w_zero(sh_work, op_w);
            nx_flags.h = 1'b0;
            nx_flags.v = even_par(sh_work, op_w);
            nx_flags.n = 1'b0;
            nx_flags.c = sh_cout;
            wr_data    = 1'b1;
        end else if (req.sel inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP}) begin
            nx_rslt  = add_rslt;
            nx_flags = add_flags;
            wr_data  = req.sel != ALU_CP;
        end else begin
            nx_rslt  = logic_rslt;
            nx_flags = logic_flags;
            wr_data  = !(req.sel inside {ALU_SCF, ALU_RCF, ALU_CCF});  // flags only
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout   <= '0;
            flag_q <= '0;
            alu_we <= W_NONE;
            hold_w <= W_NONE;
        end else begin
            alu_we <= W_NONE;  // one cycle pulse
            if (accept) hold_w <= req.w;
            if (upd) begin
                flag_q <= nx_flags;
                if (wr_data) begin
                    dout   <= nx_rslt;
                    alu_we <= op_w;
                end
            end
        end
    end

    assign cur   = flag_q;
    assign flags = {flag_q.s, flag_q.z, 1'b0, flag_q.h, 1'b0, flag_q.v, flag_q.n, flag_q.c};

endmodule

`default_nettype wire

// File: rtl/alu_logic.sv
// ALU logic unit: bitwise ops, complement, move and carry-flag instructions
`default_nettype none
`timescale 1ns/100ps

module alu_logic (
    input  alu_pkg::alu_req_t   req,
    input  alu_pkg::alu_flags_t cur,
    output alu_pkg::data_t      rslt,
    output alu_pkg::alu_flags_t nx_flags
);
    import alu_pkg::*;

    data_t src;

    always_comb begin
        src      = alu_src(req);
        rslt     = req.op0;
        nx_flags = cur;  // move keeps flags
        case (req.sel)
            ALU_MOVE: rslt = src;
            ALU_AND:  rslt = req.op0 & src;
            ALU_OR:   rslt = req.op0 | src;
            ALU_XOR:  rslt = req.op0 ^ src;
            ALU_CPL: begin
                rslt       = ~src;
                nx_flags.h = 1'b1;
                nx_flags.n = 1'b1;
            end
            ALU_SCF: begin
                nx_flags.c = 1'b1;
                nx_flags.n = 1'b0;
                nx_flags.h = 1'b0;
            end
            ALU_RCF: begin
                nx_flags.c = 1'b0;
                nx_flags.n = 1'b0;
                nx_flags.h = 1'b0;
            end
            ALU_CCF: begin
                nx_flags.c = ~cur.c;
                nx_flags.n = 1'b0;
            end
            default: ;
        endcase

        if (req.sel inside {ALU_AND, ALU_OR, ALU_XOR}) begin
            nx_flags.s = w_msb(rslt, req.w);
            nx_flags.z = w_zero(rslt, req.w);
            nx_flags.h = req.sel == ALU_AND;
            nx_flags.v = even_par(rslt, req.w);
            nx_flags.n = 1'b0;
            nx_flags.c = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu_pkg.sv
// ALU shared definitions
// widths, operation and width codes, flag and request structs, shifter states
`default_nettype none

package alu_pkg;

    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [2:0]        alu_width_t;  // one-hot, zero when idle
    typedef logic [6:0]        alu_sel_t;
    typedef logic [4:0]        shift_cnt_t;  // steps left, 16 fits

    localparam alu_width_t W_NONE = 3'd0;
    localparam alu_width_t W_BYTE = 3'd1;
    localparam alu_width_t W_WORD = 3'd2;
    localparam alu_width_t W_LONG = 3'd4;

    localparam alu_sel_t ALU_MOVE = 7'd0;
    localparam alu_sel_t ALU_ADD  = 7'd1;
    localparam alu_sel_t ALU_ADC  = 7'd2;
    localparam alu_sel_t ALU_SUB  = 7'd3;
    localparam alu_sel_t ALU_SBC  = 7'd4;
    localparam alu_sel_t ALU_CP   = 7'd5;
    localparam alu_sel_t ALU_AND  = 7'd6;
    localparam alu_sel_t ALU_OR   = 7'd7;
    localparam alu_sel_t ALU_XOR  = 7'd8;
    localparam alu_sel_t ALU_CPL  = 7'd9;
    localparam alu_sel_t ALU_SCF  = 7'd10;
    localparam alu_sel_t ALU_RCF  = 7'd11;
    localparam alu_sel_t ALU_CCF  = 7'd12;
    localparam alu_sel_t ALU_RLC  = 7'd13;
    localparam alu_sel_t ALU_RRC  = 7'd14;
    localparam alu_sel_t ALU_RL   = 7'd15;
    localparam alu_sel_t ALU_RR   = 7'd16;
    localparam alu_sel_t ALU_SLA  = 7'd17;
    localparam alu_sel_t ALU_SRA  = 7'd18;
    localparam alu_sel_t ALU_SLL  = 7'd19;
    localparam alu_sel_t ALU_SRL  = 7'd20;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;  // overflow or parity
        logic n;
        logic c;
    } alu_flags_t;

    typedef struct packed {
        alu_sel_t   sel;
        alu_width_t w;
        data_t      op0;      // destination
        data_t      op1;      // source
        data_t      imm;      // alternative source
        logic       sel_imm;
    } alu_req_t;

    typedef enum logic {
        SH_IDLE,
        SH_RUN
    } shift_state_t;

    function automatic logic [4:0] w_top(alu_width_t w);
        case (w)
            W_BYTE:  return 5'd7;
            W_WORD:  return 5'd15;
            W_LONG:  return 5'd31;
            default: return 5'd31;
        endcase
    endfunction

    function automatic logic w_msb(data_t x, alu_width_t w);
        return x[w_top(w)];
    endfunction

    function automatic logic w_zero(data_t x, alu_width_t w);
        case (w)
            W_BYTE:  return x[7:0] == 8'd0;
            W_WORD:  return x[15:0] == 16'd0;
            default: return x == '0;
        endcase
    endfunction

    // even parity, low byte or low halfword
    function automatic logic even_par(data_t x, alu_width_t w);
        return (w == W_BYTE) ? ~^x[7:0] : ~^x[15:0];
    endfunction

    function automatic data_t alu_src(alu_req_t req);
        return req.sel_imm ? req.imm : req.op1;
    endfunction

    function automatic logic is_shift(alu_sel_t sel);
        return sel inside {ALU_RLC, ALU_RRC, ALU_RL, ALU_RR,
                           ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL};
    endfunction

endpackage

`default_nettype wire

// File: rtl/alu_shifter.sv
// ALU rotate/shift engine
// one bit per cycle within the width, count 1 to 16
`default_nettype none
`timescale 1ns/100ps

module alu_shifter (
    input  logic              clk,
    input  logic              rst,
    input  alu_pkg::alu_req_t req,
    input  logic              carry,
    output alu_pkg::data_t    work,
    output logic              cout,
    output logic              done,
    output logic              busy
);
    import alu_pkg::*;

    shift_state_t state;
    data_t        work_q, src, x;
    logic         cy_q, cin, fill, left, idle, start, step;
    shift_cnt_t   cnt_q, remain;
    alu_sel_t     sel_q, sel;
    alu_width_t   w_q, w;
    logic [4:0]   msb;

    assign src    = alu_src(req);
    assign idle   = state == SH_IDLE;
    assign start  = idle && req.w != W_NONE && is_shift(req.sel);
    assign step   = start || state == SH_RUN;
    assign sel    = idle ? req.sel : sel_q;  // req ignored while running
    assign w      = idle ? req.w : w_q;
    assign x      = idle ? req.op0 : work_q;
    assign cin    = idle ? carry : cy_q;
    assign remain = idle ? {src[3:0] == 4'd0, src[3:0]} : cnt_q;  // 0 means 16
    assign done   = step && remain == 5'd1;
    assign busy   = state == SH_RUN;

    // one step, value goes out before the edge that stores it
    always_comb begin
        msb  = w_top(w);
        left = sel inside {ALU_RLC, ALU_RL, ALU_SLA, ALU_SLL};
        case (sel)
            ALU_RL, ALU_RR:   fill = cin;
            ALU_RLC, ALU_SRA: fill = x[msb];
            ALU_RRC:          fill = x[0];
            default:          fill = 1'b0;
        endcase
        if (left) begin
            work = {x[30:0], fill};
            cout = x[msb];
        end else begin
            work      = x >> 1;
            work[msb] = fill;
            cout      = x[0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SH_IDLE;
            cnt_q <= '0;
            sel_q <= ALU_MOVE;
            w_q   <= W_NONE;
        end else begin
            if (step) begin
                state <= done ? SH_IDLE : SH_RUN;
                cnt_q <= remain - 5'd1;
            end
            if (start) begin
                sel_q <= req.sel;
                w_q   <= req.w;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            work_q <= work;
            cy_q   <= cout;  // chains through carry on RL/RR
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu_top.sv
// ALU top level
// request fans out to adder, logic and shifter, one register stage behind them
`default_nettype none
`timescale 1ns/100ps

module alu_top (
    input  logic                clk,
    input  logic                rst,
    input  alu_pkg::alu_req_t   req,
    output alu_pkg::data_t      dout,
    output logic [7:0]          flags,
    output alu_pkg::alu_width_t alu_we,
    output logic                busy
);
    import alu_pkg::*;

    data_t      add_rslt, logic_rslt, sh_work;
    alu_flags_t add_flags, logic_flags, cur;
    logic       sh_cout, sh_done;

    alu_adder u_adder (
        .req      (req),
        .carry    (cur.c),
        .sum      (add_rslt),
        .nx_flags (add_flags)
    );

    alu_logic u_logic (
        .req      (req),
        .cur      (cur),
        .rslt     (logic_rslt),
        .nx_flags (logic_flags)
    );

    alu_shifter u_shifter (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .carry (cur.c),
        .work  (sh_work),
        .cout  (sh_cout),
        .done  (sh_done),
        .busy  (busy)
    );

    alu_flags u_flags (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .add_rslt    (add_rslt),
        .logic_rslt  (logic_rslt),
        .sh_work     (sh_work),
        .add_flags   (add_flags),
        .logic_flags (logic_flags),
        .sh_cout     (sh_cout),
        .sh_done     (sh_done),
        .sh_busy     (busy),
        .cur         (cur),
        .dout        (dout),
        .flags       (flags),
        .alu_we      (alu_we)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the ALU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps --top-module alu_tb -f src.f
out=$(./obj_dir/Valu_tb)
echo "$out"
if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// File: src.f
rtl/alu_pkg.sv
rtl/alu_adder.sv
rtl/alu_logic.sv
rtl/alu_shifter.sv
rtl/alu_flags.sv
rtl/alu_top.sv
bench/alu_checker.sv
bench/alu_tb.sv
